//--- vlog.f
+incdir+include
logic/mmu_pkg.sv
logic/tlb_if.sv
logic/tlb.sv
logic/page_walker.sv
logic/translate_ctrl.sv
logic/mmu_top.sv
tests/tb_clkgen.sv
tests/mmu_checker.sv
tests/mmu_tb.sv

//--- tests/mmu_testdata.hex
// Words 0 to 63 hold the page table, ppn then unused, valid, r, w, x, global bits
// Records follow as op, vpn (8 bits), asid, access; op 1 is a request, 2 a flush, 0 the end
20018 2005C 2009A 200DE 20118 20140 2019A 201DE
20218 2025C 2029A 202DE 20318 2035C 2039A 203DE
20418 2045C 2049A 204DE 20518 2055C 2059A 205DE
20618 2065C 2069A 206DE 20718 2075C 2079A 207DE
20818 2085C 2089A 208DE 20918 2095C 2099A 209DE
20A18 20A5C 20A9A 20ADE 20B18 20B5C 20B9A 20BDE
20C1F 20C59 20C9A 20CDE 20D18 20D5C 20D9A 20DDE
20E18 20E5C 20E9A 20EDE 20F18 20F5C 20F9A 20FDE
10110 10110 10111 10112 10120 13030 13070 13151
13190 10510 10510 20000 10110 13070
20000 11010 11110 11211 11312 11410 11510 11610 11710 11810
11110 11211 11312 11410 11510 11610 11710 11810 11010 00000

//--- tests/mmu_tb.sv
`timescale 1ns/1ps
`include "mmu_defines.svh"

module mmu_tb;

    localparam int NumWays   = `MMU_NUM_WAYS;
    localparam int TableSize = 1 << `MMU_VPN_W;
    localparam int DataSize  = 128;
    localparam int WaitLimit = 4 * `MMU_MEM_TIMEOUT;

    logic                clk_i;
    logic                rst_ni;
    logic                req_valid_i;
    mmu_pkg::vpn_t       req_vpn_i;
    mmu_pkg::asid_t      req_asid_i;
    mmu_pkg::access_e    req_access_i;
    logic                busy_o;
    logic                resp_valid_o;
    mmu_pkg::ppn_t       resp_ppn_o;
    logic                resp_fault_o;
    logic                flush_i;
    logic                flush_done_o;
    logic                mem_req_o;
    mmu_pkg::vpn_t       mem_addr_o;
    logic                mem_valid_i;
    mmu_pkg::pte_t       mem_rdata_i;

    logic [19:0]         tdata [DataSize];
    int                  errors = 0;
    int                  checks = 0;
    int                  mem_reqs = 0;
    logic                aborted = 1'b0;

    logic [31:0]         lcg_state = 32'd10;
    logic                mem_pending = 1'b0;
    int                  mem_delay = 0;
    mmu_pkg::vpn_t       mem_addr_q;

    // Reference copy of the cached pages
    logic                model_valid [NumWays];
    mmu_pkg::vpn_t       model_vpn [NumWays];
    mmu_pkg::asid_t      model_asid [NumWays];
    logic                model_global [NumWays];
    int                  model_idx = 0;

    tb_clkgen clkgen0 (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    mmu_top dut0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .req_vpn_i    (req_vpn_i),
        .req_asid_i   (req_asid_i),
        .req_access_i (req_access_i),
        .busy_o       (busy_o),
        .resp_valid_o (resp_valid_o),
        .resp_ppn_o   (resp_ppn_o),
        .resp_fault_o (resp_fault_o),
        .flush_i      (flush_i),
        .flush_done_o (flush_done_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_valid_i  (mem_valid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    bind mmu_top mmu_checker checker0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .busy_o       (busy_o),
        .flush_i      (flush_i),
        .flush_done_o (flush_done_o),
        .mem_req_o    (mem_req_o),
        .mem_valid_i  (mem_valid_i)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////////////////////

    // Answers 1 to 4 cycles after the request
    always @(negedge clk_i) begin
        mem_valid_i = 1'b0;
        if (mem_pending) begin
            if (mem_delay <= 1) begin
                // Address held until the answer
                check_value("mem_addr_o", mem_addr_o, req_vpn_i);
                mem_valid_i = 1'b1;
                mem_rdata_i = mmu_pkg::pte_t'(tdata[mem_addr_q][17:0]);
                mem_pending = 1'b0;
            end else begin
                mem_delay--;
            end
        end
        if (mem_req_o === 1'b1) begin
            check_value("mem_addr_o", mem_addr_o, req_vpn_i);
            lcg_state   = lcg_next(lcg_state);
            mem_delay   = 1 + int'(lcg_state[17:16]);
            mem_addr_q  = mem_addr_o;
            mem_pending = 1'b1;
            mem_reqs++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected)
            else begin
                errors++;
                $display("[FAIL] %s: got %h, expected %h", name, got, expected);
            end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        aborted = 1'b1;
        $display("Timed out waiting for %s", what);
    endtask

    function automatic logic model_hit(input mmu_pkg::vpn_t vpn, input mmu_pkg::asid_t asid);
        for (int i = 0; i < NumWays; i++) begin
            if (model_valid[i] && model_vpn[i] == vpn &&
                (model_asid[i] == asid || model_global[i])) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic model_refill(input mmu_pkg::vpn_t vpn, input mmu_pkg::asid_t asid,
                                input logic is_global);
        model_valid[model_idx]  = 1'b1;
        model_vpn[model_idx]    = vpn;
        model_asid[model_idx]   = asid;
        model_global[model_idx] = is_global;
        model_idx = (model_idx + 1) % NumWays;
    endtask

    task automatic run_request(input logic [19:0] rec);
        mmu_pkg::vpn_t    vpn;
        mmu_pkg::asid_t   asid;
        mmu_pkg::access_e acc;
        mmu_pkg::pte_t    pte;
        logic             exp_hit;
        logic             allowed;
        logic             exp_fault;
        mmu_pkg::ppn_t    exp_ppn;
        int               reqs_before;
        int               cycles;

        vpn  = rec[13:8];
        asid = rec[7:4];
        acc  = mmu_pkg::access_e'(rec[1:0]);
        pte  = mmu_pkg::pte_t'(tdata[vpn][17:0]);
        case (acc)
            mmu_pkg::ACC_READ:  allowed = pte.prot.readable;
            mmu_pkg::ACC_WRITE: allowed = pte.prot.writable;
            mmu_pkg::ACC_EXEC:  allowed = pte.prot.executable;
            default:            allowed = 1'b0;
        endcase
        exp_fault = !pte.prot.valid || !allowed;
        exp_ppn   = exp_fault ? '0 : pte.ppn;
        exp_hit   = model_hit(vpn, asid);

        cycles = 0;
        while (busy_o !== 1'b0 && cycles < WaitLimit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (busy_o !== 1'b0) begin
            note_timeout("busy_o to fall before a request");
            return;
        end
        reqs_before  = mem_reqs;
        req_valid_i  = 1'b1;
        req_vpn_i    = vpn;
        req_asid_i   = asid;
        req_access_i = acc;
        @(negedge clk_i);
        req_valid_i = 1'b0;
        check_value("busy_o", busy_o, 1'b1);

        cycles = 1;
        while (resp_valid_o !== 1'b1 && cycles < WaitLimit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (resp_valid_o !== 1'b1) begin
            note_timeout("resp_valid_o");
            return;
        end
        check_value("resp_ppn_o", resp_ppn_o, exp_ppn);
        check_value("resp_fault_o", resp_fault_o, exp_fault);
        check_value("busy_o", busy_o, 1'b0);
        check_value("mem_req_o count", mem_reqs - reqs_before, exp_hit ? 0 : 1);
        if (exp_hit) begin
            check_value("resp_valid_o latency", cycles, 2);
        end else if (pte.prot.valid) begin
            model_refill(vpn, asid, pte.prot.is_global);
        end
    endtask

    task automatic run_flush();
        int cycles;

        cycles = 0;
        while (busy_o !== 1'b0 && cycles < WaitLimit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (busy_o !== 1'b0) begin
            note_timeout("busy_o to fall before a flush");
            return;
        end
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        check_value("flush_done_o", flush_done_o, 1'b1);
        for (int i = 0; i < NumWays; i++) begin
            model_valid[i] = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [19:0] rec;
        int          idx;
        int          cycles;
        int          protocol_errors;

        req_valid_i  = 1'b0;
        req_vpn_i    = '0;
        req_asid_i   = '0;
        req_access_i = mmu_pkg::ACC_READ;
        flush_i      = 1'b0;
        mem_valid_i  = 1'b0;
        mem_rdata_i  = '0;
        for (int i = 0; i < NumWays; i++) begin
            model_valid[i] = 1'b0;
        end
        $readmemh("tests/mmu_testdata.hex", tdata);

        cycles = 0;
        while (rst_ni !== 1'b1 && cycles < 20) begin
            @(negedge clk_i);
            cycles++;
        end
        if (rst_ni !== 1'b1) begin
            note_timeout("reset release");
        end else begin
            check_value("resp_valid_o", resp_valid_o, 1'b0);
            check_value("flush_done_o", flush_done_o, 1'b0);
            check_value("mem_req_o", mem_req_o, 1'b0);
            check_value("busy_o", busy_o, 1'b0);
        end

        idx = TableSize;
        while (!aborted && idx < DataSize && tdata[idx][19:16] != 4'h0) begin
            rec = tdata[idx];
            if (rec[19:16] == 4'h1) begin
                run_request(rec);
            end else if (rec[19:16] == 4'h2) begin
                run_flush();
            end else begin
                errors++;
                $display("Unknown operation %h in record %0d", rec[19:16], idx);
            end
            idx++;
        end
        if (idx == TableSize) begin
            errors++;
            $display("Test data holds no records");
        end

        protocol_errors = dut0.checker0.fail_count;
        $display("checks %0d, errors %0d, protocol errors %0d, memory reads %0d",
                 checks, errors, protocol_errors, mem_reqs);
        if (errors == 0 && protocol_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/mmu_checker.sv
`timescale 1ns/1ps

module mmu_checker (
    input logic clk_i,
    input logic rst_ni,
    input logic req_valid_i,
    input logic busy_o,
    input logic flush_i,
    input logic flush_done_o,
    input logic mem_req_o,
    input logic mem_valid_i
);

    int unsigned fail_count = 0;
    logic        mem_open_q;

    // Memory read in flight
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_open_q <= 1'b0;
        end else if (mem_req_o) begin
            mem_open_q <= 1'b1;
        end else if (mem_valid_i) begin
            mem_open_q <= 1'b0;
        end
    end

    req_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> !busy_o)
        else begin
            fail_count++;
            $error("request given while busy_o is high");
        end

    second_mem_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o |-> !mem_open_q)
        else begin
            fail_count++;
            $error("second memory request before the memory answered");
        end

    flush_answered: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> flush_done_o)
        else begin
            fail_count++;
            $error("flush_done_o missing one cycle after flush_i");
        end

    flush_done_alone: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_done_o |-> $past(flush_i))
        else begin
            fail_count++;
            $error("flush_done_o without a flush_i one cycle earlier");
        end

endmodule

//--- tests/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_no
);

    localparam int ResetCycles = 8;

    // 40 ns period
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- logic/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
    input  logic             clk_i,
    input  logic             rst_ni,

    input  logic             req_valid_i,
    input  mmu_pkg::vpn_t    req_vpn_i,
    input  mmu_pkg::asid_t   req_asid_i,
    input  mmu_pkg::access_e req_access_i,
    output logic             busy_o,
    output logic             resp_valid_o,
    output mmu_pkg::ppn_t    resp_ppn_o,
    output logic             resp_fault_o,

    input  logic             flush_i,
    output logic             flush_done_o,

    output logic             mem_req_o,
    output mmu_pkg::vpn_t    mem_addr_o,
    input  logic             mem_valid_i,
    input  mmu_pkg::pte_t    mem_rdata_i
);

    logic           walk_start;
    mmu_pkg::vpn_t  walk_vpn;
    mmu_pkg::asid_t walk_asid;
    logic           walk_done;
    mmu_pkg::pte_t  walk_pte;
    logic           walk_err;

    tlb_lookup_if lookup_if ();
    tlb_refill_if refill_if ();

    translate_ctrl ctrl0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .req_vpn_i    (req_vpn_i),
        .req_asid_i   (req_asid_i),
        .req_access_i (req_access_i),
        .busy_o       (busy_o),
        .resp_valid_o (resp_valid_o),
        .resp_ppn_o   (resp_ppn_o),
        .resp_fault_o (resp_fault_o),
        .lookup       (lookup_if.requester),
        .walk_start_o (walk_start),
        .walk_vpn_o   (walk_vpn),
        .walk_asid_o  (walk_asid),
        .walk_done_i  (walk_done),
        .walk_pte_i   (walk_pte),
        .walk_err_i   (walk_err)
    );

    tlb tlb0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lookup       (lookup_if.responder),
        .refill       (refill_if.sink),
        .flush_req_i  (flush_i),
        .flush_resp_o (flush_done_o)
    );

    page_walker walker0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .walk_start_i (walk_start),
        .walk_vpn_i   (walk_vpn),
        .walk_asid_i  (walk_asid),
        .walk_done_o  (walk_done),
        .walk_pte_o   (walk_pte),
        .walk_err_o   (walk_err),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_valid_i  (mem_valid_i),
        .mem_rdata_i  (mem_rdata_i),
        .refill       (refill_if.source)
    );

endmodule

//--- logic/translate_ctrl.sv
`timescale 1ns/1ps

module translate_ctrl (
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic               req_valid_i,
    input  mmu_pkg::vpn_t      req_vpn_i,
    input  mmu_pkg::asid_t     req_asid_i,
    input  mmu_pkg::access_e   req_access_i,
    output logic               busy_o,
    output logic               resp_valid_o,
    output mmu_pkg::ppn_t      resp_ppn_o,
    output logic               resp_fault_o,

    tlb_lookup_if.requester    lookup,

    output logic               walk_start_o,
    output mmu_pkg::vpn_t      walk_vpn_o,
    output mmu_pkg::asid_t     walk_asid_o,
    input  logic               walk_done_i,
    input  mmu_pkg::pte_t      walk_pte_i,
    input  logic               walk_err_i
);

    mmu_pkg::ctrl_state_e state_q, state_d;
    logic                 sent_q, sent_d;
    logic                 accept;

    mmu_pkg::vpn_t        vpn_q;
    mmu_pkg::asid_t       asid_q;
    mmu_pkg::access_e     access_q;

    mmu_pkg::ppn_t        chk_ppn;
    mmu_pkg::page_prot_t  chk_prot;
    logic                 allowed;
    logic                 fault;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////////////////////

    // A new request may arrive in the response cycle
    assign accept = req_valid_i && (state_q == mmu_pkg::CTRL_IDLE || resp_valid_o);

    assign resp_valid_o =
        (state_q == mmu_pkg::CTRL_LOOKUP && sent_q && lookup.resp_hit) ||
        (state_q == mmu_pkg::CTRL_WALK && walk_done_i);

    assign busy_o = (state_q != mmu_pkg::CTRL_IDLE) && !resp_valid_o;

    assign walk_start_o = state_q == mmu_pkg::CTRL_LOOKUP && sent_q && !lookup.resp_hit;
    assign walk_vpn_o   = vpn_q;
    assign walk_asid_o  = asid_q;

    assign lookup.req_valid = state_q == mmu_pkg::CTRL_LOOKUP && !sent_q;
    assign lookup.req_vpn   = vpn_q;
    assign lookup.req_asid  = asid_q;

    always_comb begin
        state_d = state_q;
        sent_d  = sent_q;
        if (state_q == mmu_pkg::CTRL_LOOKUP && !sent_q) begin
            sent_d = 1'b1;
        end
        if (walk_start_o) begin
            state_d = mmu_pkg::CTRL_WALK;
        end
        if (resp_valid_o) begin
            state_d = mmu_pkg::CTRL_IDLE;
        end
        if (accept) begin
            state_d = mmu_pkg::CTRL_LOOKUP;
            sent_d  = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= mmu_pkg::CTRL_IDLE;
            sent_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            sent_q  <= sent_d;
        end
    end

    // Request held while busy
    always_ff @(posedge clk_i) begin
        if (accept) begin
            vpn_q    <= req_vpn_i;
            asid_q   <= req_asid_i;
            access_q <= req_access_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Permission check
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (state_q == mmu_pkg::CTRL_WALK) begin
            chk_ppn  = walk_pte_i.ppn;
            chk_prot = walk_pte_i.prot;
        end else begin
            chk_ppn  = lookup.resp_ppn;
            chk_prot = lookup.resp_perm;
        end
        unique case (access_q)
            mmu_pkg::ACC_READ:  allowed = chk_prot.readable;
            mmu_pkg::ACC_WRITE: allowed = chk_prot.writable;
            mmu_pkg::ACC_EXEC:  allowed = chk_prot.executable;
            default:            allowed = 1'b0;
        endcase
    end

    assign fault = (state_q == mmu_pkg::CTRL_WALK && walk_err_i) ||
                   !chk_prot.valid || !allowed;

    assign resp_fault_o = fault;
    assign resp_ppn_o   = fault ? '0 : chk_ppn;

endmodule

//--- logic/page_walker.sv
`timescale 1ns/1ps
`include "mmu_defines.svh"

module page_walker (
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic               walk_start_i,
    input  mmu_pkg::vpn_t      walk_vpn_i,
    input  mmu_pkg::asid_t     walk_asid_i,
    output logic               walk_done_o,
    output mmu_pkg::pte_t      walk_pte_o,
    output logic               walk_err_o,

    output logic               mem_req_o,
    output mmu_pkg::vpn_t      mem_addr_o,
    input  logic               mem_valid_i,
    input  mmu_pkg::pte_t      mem_rdata_i,

    tlb_refill_if.source       refill
);

    localparam int TimerW = $clog2(`MMU_MEM_TIMEOUT + 1);

    mmu_pkg::walk_state_e state_q;
    logic [TimerW-1:0]    timer_q;
    logic                 refill_q;
    mmu_pkg::vpn_t        vpn_q;
    mmu_pkg::asid_t       asid_q;
    mmu_pkg::pte_t        pte_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= mmu_pkg::WALK_IDLE;
            timer_q     <= '0;
            mem_req_o   <= 1'b0;
            walk_done_o <= 1'b0;
            walk_err_o  <= 1'b0;
            refill_q    <= 1'b0;
        end else begin
            mem_req_o   <= 1'b0;
            walk_done_o <= 1'b0;
            walk_err_o  <= 1'b0;
            refill_q    <= 1'b0;
            unique case (state_q)
                mmu_pkg::WALK_IDLE: begin
                    if (walk_start_i) begin
                        mem_req_o <= 1'b1;
                        timer_q   <= '0;
                        state_q   <= mmu_pkg::WALK_WAIT;
                    end
                end
                mmu_pkg::WALK_WAIT: begin
                    if (mem_valid_i) begin
                        walk_done_o <= 1'b1;
                        // Invalid entries go back to the controller only
                        refill_q    <= mem_rdata_i.prot.valid;
                        state_q     <= mmu_pkg::WALK_IDLE;
                    end else if (timer_q == TimerW'(`MMU_MEM_TIMEOUT - 1)) begin
                        walk_done_o <= 1'b1;
                        walk_err_o  <= 1'b1;
                        state_q     <= mmu_pkg::WALK_IDLE;
                    end else begin
                        timer_q <= timer_q + 1'b1;
                    end
                end
                default: state_q <= mmu_pkg::WALK_IDLE;
            endcase
        end
    end

    // Request and entry payload
    always_ff @(posedge clk_i) begin
        if (state_q == mmu_pkg::WALK_IDLE && walk_start_i) begin
            vpn_q  <= walk_vpn_i;
            asid_q <= walk_asid_i;
        end
        if (state_q == mmu_pkg::WALK_WAIT) begin
            if (mem_valid_i) begin
                pte_q <= mem_rdata_i;
            end else if (timer_q == TimerW'(`MMU_MEM_TIMEOUT - 1)) begin
                pte_q <= '0;
            end
        end
    end

    assign mem_addr_o = vpn_q;
    assign walk_pte_o = pte_q;

    assign refill.refill_valid = refill_q;
    assign refill.refill_asid  = asid_q;
    assign refill.refill_vpn   = vpn_q;
    assign refill.refill_ppn   = pte_q.ppn;
    assign refill.refill_perm  = pte_q.prot;

endmodule

//--- logic/tlb.sv
`timescale 1ns/1ps
`include "mmu_defines.svh"

module tlb (
    input  logic            clk_i,
    input  logic            rst_ni,
    tlb_lookup_if.responder lookup,
    tlb_refill_if.sink      refill,
    input  logic            flush_req_i,
    output logic            flush_resp_o
);

    localparam int NumWays = `MMU_NUM_WAYS;
    localparam int WaysW   = $clog2(NumWays);

    typedef struct packed {
        mmu_pkg::page_prot_t prot;
        mmu_pkg::vpn_t       vpn;
        mmu_pkg::asid_t      asid;
        mmu_pkg::ppn_t       ppn;
    } tlb_entry_t;

    tlb_entry_t          entries_q [NumWays];
    logic [NumWays-1:0]  valid_q;
    logic [WaysW-1:0]    repl_idx_q;

    logic [NumWays-1:0]  hits;
    logic                hit;
    tlb_entry_t          hit_entry;

    logic                hit_q;
    mmu_pkg::ppn_t       hit_ppn_q;
    mmu_pkg::page_prot_t hit_perm_q;

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    // All ways compared at once
    always_comb begin
        for (int i = 0; i < NumWays; i++) begin
            hits[i] = valid_q[i] &&
                      entries_q[i].vpn == lookup.req_vpn &&
                      (entries_q[i].asid == lookup.req_asid ||
                       entries_q[i].prot.is_global);
        end
    end

    always_comb begin
        hit       = 1'b0;
        hit_entry = '0;
        for (int i = 0; i < NumWays; i++) begin
            if (hits[i]) begin
                hit       = 1'b1;
                hit_entry = entries_q[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_q        <= 1'b0;
            flush_resp_o <= 1'b0;
        end else begin
            hit_q        <= lookup.req_valid && hit;
            flush_resp_o <= flush_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup.req_valid) begin
            hit_ppn_q  <= hit_entry.ppn;
            hit_perm_q <= hit_entry.prot;
        end
    end

    assign lookup.resp_hit  = hit_q;
    assign lookup.resp_ppn  = hit_ppn_q;
    assign lookup.resp_perm = hit_perm_q;

    ////////////////////////////////////////////////////////////////////////////
    // Refill and flush
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NumWays; i++) begin
            if (refill.refill_valid && repl_idx_q == WaysW'(i)) begin
                entries_q[i] <= tlb_entry_t'{
                    refill.refill_perm,
                    refill.refill_vpn,
                    refill.refill_asid,
                    refill.refill_ppn
                };
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            repl_idx_q <= '0;
        end else begin
            for (int i = 0; i < NumWays; i++) begin
                if (refill.refill_valid && repl_idx_q == WaysW'(i)) begin
                    valid_q[i] <= 1'b1;
                end
            end
            // Flush wins over a refill on the same edge
            if (flush_req_i) begin
                valid_q <= '0;
            end
            if (refill.refill_valid) begin
                repl_idx_q <= (repl_idx_q == WaysW'(NumWays - 1)) ? '0 : repl_idx_q + 1'b1;
            end
        end
    end

endmodule

//--- logic/tlb_if.sv
`timescale 1ns/1ps

// Lookup request pulse and registered response
interface tlb_lookup_if;
    logic                req_valid;
    mmu_pkg::asid_t      req_asid;
    mmu_pkg::vpn_t       req_vpn;
    logic                resp_hit;
    mmu_pkg::ppn_t       resp_ppn;
    mmu_pkg::page_prot_t resp_perm;

    modport requester (
        output req_valid, req_asid, req_vpn,
        input  resp_hit, resp_ppn, resp_perm
    );

    modport responder (
        input  req_valid, req_asid, req_vpn,
        output resp_hit, resp_ppn, resp_perm
    );
endinterface

// Refill pulse with the new entry
interface tlb_refill_if;
    logic                refill_valid;
    mmu_pkg::asid_t      refill_asid;
    mmu_pkg::vpn_t       refill_vpn;
    mmu_pkg::ppn_t       refill_ppn;
    mmu_pkg::page_prot_t refill_perm;

    modport source (
        output refill_valid, refill_asid, refill_vpn, refill_ppn, refill_perm
    );

    modport sink (
        input  refill_valid, refill_asid, refill_vpn, refill_ppn, refill_perm
    );
endinterface

//--- logic/mmu_pkg.sv
`include "mmu_defines.svh"

package mmu_pkg;

    typedef logic [`MMU_VPN_W-1:0]  vpn_t;
    typedef logic [`MMU_PPN_W-1:0]  ppn_t;
    typedef logic [`MMU_ASID_W-1:0] asid_t;

    // Page permissions, 5 bits
    typedef struct packed {
        logic valid;
        logic readable;
        logic writable;
        logic executable;
        logic is_global;
    } page_prot_t;

    // Page table word as stored in memory
    typedef struct packed {
        ppn_t       ppn;
        logic       unused;
        page_prot_t prot;
    } pte_t;

    typedef enum logic [1:0] {
        ACC_READ  = 2'd0,
        ACC_WRITE = 2'd1,
        ACC_EXEC  = 2'd2
    } access_e;

    typedef enum logic [1:0] {
        CTRL_IDLE   = 2'd0,
        CTRL_LOOKUP = 2'd1,
        CTRL_WALK   = 2'd2
    } ctrl_state_e;

    typedef enum logic {
        WALK_IDLE = 1'b0,
        WALK_WAIT = 1'b1
    } walk_state_e;

endpackage

//--- include/mmu_defines.svh
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// TLB size
`define MMU_NUM_WAYS 8

// Field widths
`define MMU_VPN_W 6
`define MMU_PPN_W 12
`define MMU_ASID_W 4

// Cycles the walker waits for a memory answer
`define MMU_MEM_TIMEOUT 64

`endif
